/* hdl/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path width
`define XLEN 32

// word address of the first fetch
`define RESET_PC 30'h0

// architectural registers, x0 included
`define REG_COUNT 32

`endif

/* hdl/isa_pkg.sv */
package isa_pkg;

   typedef logic [4:0] reg_idx_t;
   typedef logic [2:0] funct3_t;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      op     = 7'b0110011,
      op_imm = 7'b0010011,
      lui    = 7'b0110111,
      load   = 7'b0000011,
      store  = 7'b0100011,
      branch = 7'b1100011,
      jal    = 7'b1101111
   } opcode_e;

   localparam funct3_t f3_add_sub = 3'b000; // sub when bit 30 is set
   localparam funct3_t f3_sll     = 3'b001;
   localparam funct3_t f3_slt     = 3'b010;
   localparam funct3_t f3_xor     = 3'b100;
   localparam funct3_t f3_srl     = 3'b101;
   localparam funct3_t f3_or      = 3'b110;
   localparam funct3_t f3_and     = 3'b111;
   localparam funct3_t f3_beq     = 3'b000;
   localparam funct3_t f3_bne     = 3'b001;

endpackage

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt,
      alu_sll,
      alu_srl,
      alu_pass_b // lui
   } alu_op_e;

   // source of the register write-back value
   typedef enum logic [1:0] {
      wb_alu,
      wb_load,
      wb_pc_plus_4,
      wb_none
   } wb_sel_e;

   typedef enum logic {op1_rs1, op1_pc} op1_sel_e;
   typedef enum logic {op2_rs2, op2_imm} op2_sel_e;

endpackage

/* hdl/instruction_fetch_stage.sv */
`timescale 1ns/1ns
`include "core_settings.svh"

module instruction_fetch_stage (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              freeze_i,
   input  logic              stall_i,
   input  logic              instr_ready_i,
   input  logic [`XLEN-1:0]  instr_data_i,
   input  logic              branch_taken_i,
   input  logic [29:0]       branch_target_i,
   output logic [29:0]       instr_cache_address_o,
   output logic [`XLEN-1:0]  instr_if_id_o,
   output logic [29:0]       pc_if_id_o,
   output logic              valid_if_id_o
);
   logic [29:0] pc;

   assign instr_cache_address_o = pc;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pc <= `RESET_PC;
         valid_if_id_o <= 1'b0;
      end else if (!freeze_i) begin
         if (branch_taken_i) begin // redirect, drop the fetched word
            pc <= branch_target_i;
            valid_if_id_o <= 1'b0;
         end else if (!stall_i) begin
            if (instr_ready_i)
               pc <= pc + 30'd1;
            valid_if_id_o <= instr_ready_i; // bubble while cache is busy
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!freeze_i && !stall_i) begin
         instr_if_id_o <= instr_data_i;
         pc_if_id_o <= pc;
      end
   end

endmodule

/* hdl/instruction_decode_stage.sv */
`timescale 1ns/1ns
`include "core_settings.svh"

module instruction_decode_stage (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                freeze_i,
   input  logic                flush_i,
   input  logic [`XLEN-1:0]    instr_i,
   input  logic [29:0]         pc_i,
   input  logic                valid_i,
   input  isa_pkg::reg_idx_t   ex_rd_i,
   input  logic                ex_wb_en_i,
   input  isa_pkg::reg_idx_t   mem_rd_i,
   input  logic                mem_wb_en_i,
   input  isa_pkg::reg_idx_t   wb_rd_i,
   input  logic                wb_en_i,
   input  logic [`XLEN-1:0]    wb_data_i,
   output logic                hazard_stall_o,
   output logic [`XLEN-1:0]    rs1_value_id_ex_o,
   output logic [`XLEN-1:0]    rs2_value_id_ex_o,
   output logic [`XLEN-1:0]    imm_value_id_ex_o,
   output logic [29:0]         pc_id_ex_o,
   output isa_pkg::reg_idx_t   rd_id_ex_o,
   output ctrl_pkg::alu_op_e   alu_op_id_ex_o,
   output ctrl_pkg::op1_sel_e  alu_op1_sel_id_ex_o,
   output ctrl_pkg::op2_sel_e  alu_op2_sel_id_ex_o,
   output ctrl_pkg::wb_sel_e   wb_sel_id_ex_o,
   output logic                reg_wb_en_id_ex_o,
   output logic                is_load_instr_id_ex_o,
   output logic                is_store_instr_id_ex_o,
   output logic                is_branch_instr_id_ex_o,
   output logic                is_jump_instr_id_ex_o,
   output logic                branch_ne_id_ex_o,
   output logic                valid_id_ex_o
);
   logic [`XLEN-1:0]   regs [`REG_COUNT];
   isa_pkg::opcode_e   opcode;
   isa_pkg::reg_idx_t  rs1, rs2, rd;
   isa_pkg::funct3_t   f3;
   ctrl_pkg::alu_op_e  alu_op, f3_alu_op;
   ctrl_pkg::op1_sel_e op1_sel;
   ctrl_pkg::op2_sel_e op2_sel;
   ctrl_pkg::wb_sel_e  wb_sel;
   logic [`XLEN-1:0]   imm, rs1_value, rs2_value;
   logic known, uses_rs1, uses_rs2, wb_en, is_load, is_store, is_branch, is_jump;
   logic issue;

   assign opcode = isa_pkg::opcode_e'(instr_i[6:0]);
   assign rs1 = instr_i[19:15];
   assign rs2 = instr_i[24:20];
   assign rd = instr_i[11:7];
   assign f3 = instr_i[14:12];

   // register operand still owned by an older instruction
   function automatic logic pending(isa_pkg::reg_idx_t r);
      return (r != '0) && ((ex_wb_en_i && ex_rd_i == r) || (mem_wb_en_i && mem_rd_i == r) ||
                           (wb_en_i && wb_rd_i == r));
   endfunction

   always_comb begin
      case (f3)
         isa_pkg::f3_sll: f3_alu_op = ctrl_pkg::alu_sll;
         isa_pkg::f3_slt: f3_alu_op = ctrl_pkg::alu_slt;
         isa_pkg::f3_xor: f3_alu_op = ctrl_pkg::alu_xor;
         isa_pkg::f3_srl: f3_alu_op = ctrl_pkg::alu_srl;
         isa_pkg::f3_or:  f3_alu_op = ctrl_pkg::alu_or;
         isa_pkg::f3_and: f3_alu_op = ctrl_pkg::alu_and;
         default:         f3_alu_op = ctrl_pkg::alu_add; // f3_add_sub
      endcase
   end

   always_comb begin
      known = 1'b1;
      uses_rs1 = 1'b0;
      uses_rs2 = 1'b0;
      wb_en = 1'b0;
      is_load = 1'b0;
      is_store = 1'b0;
      is_branch = 1'b0;
      is_jump = 1'b0;
      alu_op = ctrl_pkg::alu_add;
      op1_sel = ctrl_pkg::op1_rs1;
      op2_sel = ctrl_pkg::op2_imm;
      wb_sel = ctrl_pkg::wb_none;
      imm = {{20{instr_i[31]}}, instr_i[31:20]}; // I type
      case (opcode)
         isa_pkg::op: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            op2_sel = ctrl_pkg::op2_rs2;
            alu_op = (f3 == isa_pkg::f3_add_sub && instr_i[30]) ? ctrl_pkg::alu_sub : f3_alu_op;
            wb_sel = ctrl_pkg::wb_alu;
            wb_en = 1'b1;
         end
         isa_pkg::op_imm: begin
            uses_rs1 = 1'b1;
            alu_op = f3_alu_op;
            wb_sel = ctrl_pkg::wb_alu;
            wb_en = 1'b1;
         end
         isa_pkg::lui: begin
            imm = {instr_i[31:12], 12'b0};
            alu_op = ctrl_pkg::alu_pass_b;
            wb_sel = ctrl_pkg::wb_alu;
            wb_en = 1'b1;
         end
         isa_pkg::load: begin
            uses_rs1 = 1'b1;
            is_load = 1'b1;
            wb_sel = ctrl_pkg::wb_load;
            wb_en = 1'b1;
         end
         isa_pkg::store: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            is_store = 1'b1;
            imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
         end
         isa_pkg::branch: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            is_branch = 1'b1;
            known = (f3 == isa_pkg::f3_beq) || (f3 == isa_pkg::f3_bne);
            imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
         end
         isa_pkg::jal: begin
            is_jump = 1'b1;
            op1_sel = ctrl_pkg::op1_pc;
            wb_sel = ctrl_pkg::wb_pc_plus_4; // link value
            wb_en = 1'b1;
            imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
         end
         default: known = 1'b0; // decodes to a bubble
      endcase
   end

   // same-cycle write-back is bypassed to the read ports
   assign rs1_value = (rs1 == '0) ? '0 : (wb_en_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
   assign rs2_value = (rs2 == '0) ? '0 : (wb_en_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];

   assign hazard_stall_o = valid_i && known &&
                           ((uses_rs1 && pending(rs1)) || (uses_rs2 && pending(rs2)));
   assign issue = valid_i && known && !hazard_stall_o && !flush_i;

   always_ff @(posedge clk_i) begin
      if (wb_en_i && wb_rd_i != '0)
         regs[wb_rd_i] <= wb_data_i;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_id_ex_o <= 1'b0;
         reg_wb_en_id_ex_o <= 1'b0;
         is_load_instr_id_ex_o <= 1'b0;
         is_store_instr_id_ex_o <= 1'b0;
         is_branch_instr_id_ex_o <= 1'b0;
         is_jump_instr_id_ex_o <= 1'b0;
      end else if (!freeze_i) begin
         valid_id_ex_o <= issue;
         reg_wb_en_id_ex_o <= issue && wb_en;
         is_load_instr_id_ex_o <= issue && is_load;
         is_store_instr_id_ex_o <= issue && is_store;
         is_branch_instr_id_ex_o <= issue && is_branch;
         is_jump_instr_id_ex_o <= issue && is_jump;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!freeze_i) begin
         rs1_value_id_ex_o <= rs1_value;
         rs2_value_id_ex_o <= rs2_value;
         imm_value_id_ex_o <= imm;
         pc_id_ex_o <= pc_i;
         rd_id_ex_o <= rd;
         alu_op_id_ex_o <= alu_op;
         alu_op1_sel_id_ex_o <= op1_sel;
         alu_op2_sel_id_ex_o <= op2_sel;
         wb_sel_id_ex_o <= wb_sel;
         branch_ne_id_ex_o <= (f3 == isa_pkg::f3_bne);
      end
   end

endmodule

/* hdl/instruction_execution_stage.sv */
`timescale 1ns/1ns
`include "core_settings.svh"

module instruction_execution_stage (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                freeze_i,
   input  logic [`XLEN-1:0]    rs1_value_i,
   input  logic [`XLEN-1:0]    rs2_value_i,
   input  logic [`XLEN-1:0]    imm_value_i,
   input  logic [29:0]         pc_i,
   input  isa_pkg::reg_idx_t   rd_i,
   input  ctrl_pkg::alu_op_e   alu_op_i,
   input  ctrl_pkg::op1_sel_e  alu_op1_sel_i,
   input  ctrl_pkg::op2_sel_e  alu_op2_sel_i,
   input  ctrl_pkg::wb_sel_e   wb_sel_i,
   input  logic                reg_wb_en_i,
   input  logic                is_load_instr_i,
   input  logic                is_store_instr_i,
   input  logic                is_branch_instr_i,
   input  logic                is_jump_instr_i,
   input  logic                branch_ne_i,
   input  logic                valid_i,
   output logic                branch_taken_o,
   output logic [29:0]         branch_target_o,
   output logic [`XLEN-1:0]    alu_out_ex_mem_o,
   output logic [`XLEN-1:0]    rs2_ex_mem_o,
   output logic [`XLEN-1:0]    pc_plus_4_ex_mem_o,
   output isa_pkg::reg_idx_t   rd_ex_mem_o,
   output ctrl_pkg::wb_sel_e   wb_sel_ex_mem_o,
   output logic                reg_wb_en_ex_mem_o,
   output logic                is_load_instr_ex_mem_o,
   output logic                is_store_instr_ex_mem_o
);
   logic [`XLEN-1:0] pc_byte, op1, op2, alu_out, target;
   logic             cond_met;

   assign pc_byte = {pc_i, 2'b00};
   assign op1 = (alu_op1_sel_i == ctrl_pkg::op1_pc) ? pc_byte : rs1_value_i;
   assign op2 = (alu_op2_sel_i == ctrl_pkg::op2_imm) ? imm_value_i : rs2_value_i;

   always_comb begin
      case (alu_op_i)
         ctrl_pkg::alu_sub:    alu_out = op1 - op2;
         ctrl_pkg::alu_and:    alu_out = op1 & op2;
         ctrl_pkg::alu_or:     alu_out = op1 | op2;
         ctrl_pkg::alu_xor:    alu_out = op1 ^ op2;
         ctrl_pkg::alu_slt:    alu_out = {31'b0, $signed(op1) < $signed(op2)};
         ctrl_pkg::alu_sll:    alu_out = op1 << op2[4:0];
         ctrl_pkg::alu_srl:    alu_out = op1 >> op2[4:0];
         ctrl_pkg::alu_pass_b: alu_out = op2;
         default:              alu_out = op1 + op2;
      endcase
   end

   // beq and bne share one comparator
   assign cond_met = (rs1_value_i == rs2_value_i) ^ branch_ne_i;
   assign target = pc_byte + imm_value_i;
   assign branch_target_o = target[31:2];
   assign branch_taken_o = valid_i && (is_jump_instr_i || (is_branch_instr_i && cond_met));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         reg_wb_en_ex_mem_o <= 1'b0;
         is_load_instr_ex_mem_o <= 1'b0;
         is_store_instr_ex_mem_o <= 1'b0;
      end else if (!freeze_i) begin
         reg_wb_en_ex_mem_o <= valid_i && reg_wb_en_i; // invalid slot writes nothing
         is_load_instr_ex_mem_o <= valid_i && is_load_instr_i;
         is_store_instr_ex_mem_o <= valid_i && is_store_instr_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!freeze_i) begin
         alu_out_ex_mem_o <= alu_out;
         rs2_ex_mem_o <= rs2_value_i;
         pc_plus_4_ex_mem_o <= pc_byte + 32'd4;
         rd_ex_mem_o <= rd_i;
         wb_sel_ex_mem_o <= wb_sel_i;
      end
   end

endmodule

/* hdl/memory_stage.sv */
`timescale 1ns/1ns
`include "core_settings.svh"

module memory_stage (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               freeze_i,
   input  logic [`XLEN-1:0]   alu_out_i,
   input  logic [`XLEN-1:0]   rs2_i,
   input  logic [`XLEN-1:0]   pc_plus_4_i,
   input  isa_pkg::reg_idx_t  rd_i,
   input  ctrl_pkg::wb_sel_e  wb_sel_i,
   input  logic               reg_wb_en_i,
   input  logic               is_load_instr_i,
   input  logic               is_store_instr_i,
   input  logic [`XLEN-1:0]   data_cache_data_i,
   output logic [29:0]        data_cache_address_o,
   output logic [3:0]         data_cache_write_en_o,
   output logic [`XLEN-1:0]   data_cache_data_o,
   output logic               data_cache_enabled_o,
   output logic [`XLEN-1:0]   load_val_o,
   output logic [`XLEN-1:0]   alu_out_o,
   output logic [`XLEN-1:0]   pc_plus_4_o,
   output isa_pkg::reg_idx_t  rd_label_o,
   output ctrl_pkg::wb_sel_e  wb_sel_o,
   output logic               reg_wb_en_o
);
   // word accesses only
   assign data_cache_address_o = alu_out_i[31:2];
   assign data_cache_data_o = rs2_i;
   assign data_cache_write_en_o = {4{is_store_instr_i}};
   assign data_cache_enabled_o = is_load_instr_i | is_store_instr_i;

   always_ff @(posedge clk_i) begin
      if (rst_i)
         reg_wb_en_o <= 1'b0;
      else if (!freeze_i)
         reg_wb_en_o <= reg_wb_en_i;
   end

   always_ff @(posedge clk_i) begin
      if (!freeze_i) begin
         load_val_o <= data_cache_data_i; // only sampled when the cache is ready
         alu_out_o <= alu_out_i;
         pc_plus_4_o <= pc_plus_4_i;
         rd_label_o <= rd_i;
         wb_sel_o <= wb_sel_i;
      end
   end

endmodule

/* hdl/core.sv */
`timescale 1ns/1ns
`include "core_settings.svh"

module core (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              instr_cache_blocking_n_i,
   input  logic              data_cache_blocking_n_i,
   input  logic [`XLEN-1:0]  instr_cache_data_i,
   input  logic [`XLEN-1:0]  data_cache_data_i,
   output logic [31:2]       instr_cache_address_o,
   output logic [31:2]       data_cache_address_o,
   output logic [3:0]        data_cache_write_en_o,
   output logic [`XLEN-1:0]  data_cache_data_o,
   output logic              data_cache_enabled_o
);
   logic              freeze, hazard_stall, branch_taken;
   logic [29:0]       branch_target;

   logic [`XLEN-1:0]  instr_if_id;
   logic [29:0]       pc_if_id;
   logic              valid_if_id;

   logic [`XLEN-1:0]  rs1_value_id_ex, rs2_value_id_ex, imm_value_id_ex;
   logic [29:0]       pc_id_ex;
   isa_pkg::reg_idx_t rd_id_ex;
   ctrl_pkg::alu_op_e alu_op_id_ex;
   ctrl_pkg::op1_sel_e alu_op1_sel_id_ex;
   ctrl_pkg::op2_sel_e alu_op2_sel_id_ex;
   ctrl_pkg::wb_sel_e wb_sel_id_ex;
   logic reg_wb_en_id_ex, is_load_instr_id_ex, is_store_instr_id_ex;
   logic is_branch_instr_id_ex, is_jump_instr_id_ex, branch_ne_id_ex, valid_id_ex;

   logic [`XLEN-1:0]  alu_out_ex_mem, rs2_ex_mem, pc_plus_4_ex_mem;
   isa_pkg::reg_idx_t rd_ex_mem;
   ctrl_pkg::wb_sel_e wb_sel_ex_mem;
   logic reg_wb_en_ex_mem, is_load_instr_ex_mem, is_store_instr_ex_mem;

   logic [`XLEN-1:0]  load_val_mem_wb, alu_out_mem_wb, pc_plus_4_mem_wb, wb_data;
   isa_pkg::reg_idx_t rd_mem_wb;
   ctrl_pkg::wb_sel_e wb_sel_mem_wb;
   logic              reg_wb_en_mem_wb;

   // a pending redirect does not wait for the instruction cache
   assign freeze = (data_cache_enabled_o & ~data_cache_blocking_n_i) |
                   (~instr_cache_blocking_n_i & ~branch_taken);

   always_comb begin
      case (wb_sel_mem_wb)
         ctrl_pkg::wb_alu:       wb_data = alu_out_mem_wb;
         ctrl_pkg::wb_load:      wb_data = load_val_mem_wb;
         ctrl_pkg::wb_pc_plus_4: wb_data = pc_plus_4_mem_wb;
         default:                wb_data = '0;
      endcase
   end

   instruction_fetch_stage u_if (
      .clk_i(clk_i), .rst_i(rst_i), .freeze_i(freeze), .stall_i(hazard_stall),
      .instr_ready_i(instr_cache_blocking_n_i), .instr_data_i(instr_cache_data_i),
      .branch_taken_i(branch_taken), .branch_target_i(branch_target),
      .instr_cache_address_o(instr_cache_address_o), .instr_if_id_o(instr_if_id),
      .pc_if_id_o(pc_if_id), .valid_if_id_o(valid_if_id)
   );

   instruction_decode_stage u_id (
      .clk_i(clk_i), .rst_i(rst_i), .freeze_i(freeze), .flush_i(branch_taken),
      .instr_i(instr_if_id), .pc_i(pc_if_id), .valid_i(valid_if_id),
      .ex_rd_i(rd_id_ex), .ex_wb_en_i(reg_wb_en_id_ex),
      .mem_rd_i(rd_ex_mem), .mem_wb_en_i(reg_wb_en_ex_mem),
      .wb_rd_i(rd_mem_wb), .wb_en_i(reg_wb_en_mem_wb), .wb_data_i(wb_data),
      .hazard_stall_o(hazard_stall),
      .rs1_value_id_ex_o(rs1_value_id_ex), .rs2_value_id_ex_o(rs2_value_id_ex),
      .imm_value_id_ex_o(imm_value_id_ex), .pc_id_ex_o(pc_id_ex), .rd_id_ex_o(rd_id_ex),
      .alu_op_id_ex_o(alu_op_id_ex), .alu_op1_sel_id_ex_o(alu_op1_sel_id_ex),
      .alu_op2_sel_id_ex_o(alu_op2_sel_id_ex), .wb_sel_id_ex_o(wb_sel_id_ex),
      .reg_wb_en_id_ex_o(reg_wb_en_id_ex), .is_load_instr_id_ex_o(is_load_instr_id_ex),
      .is_store_instr_id_ex_o(is_store_instr_id_ex),
      .is_branch_instr_id_ex_o(is_branch_instr_id_ex),
      .is_jump_instr_id_ex_o(is_jump_instr_id_ex), .branch_ne_id_ex_o(branch_ne_id_ex),
      .valid_id_ex_o(valid_id_ex)
   );

   instruction_execution_stage u_ex (
      .clk_i(clk_i), .rst_i(rst_i), .freeze_i(freeze),
      .rs1_value_i(rs1_value_id_ex), .rs2_value_i(rs2_value_id_ex),
      .imm_value_i(imm_value_id_ex), .pc_i(pc_id_ex), .rd_i(rd_id_ex),
      .alu_op_i(alu_op_id_ex), .alu_op1_sel_i(alu_op1_sel_id_ex),
      .alu_op2_sel_i(alu_op2_sel_id_ex), .wb_sel_i(wb_sel_id_ex),
      .reg_wb_en_i(reg_wb_en_id_ex), .is_load_instr_i(is_load_instr_id_ex),
      .is_store_instr_i(is_store_instr_id_ex), .is_branch_instr_i(is_branch_instr_id_ex),
      .is_jump_instr_i(is_jump_instr_id_ex), .branch_ne_i(branch_ne_id_ex),
      .valid_i(valid_id_ex), .branch_taken_o(branch_taken), .branch_target_o(branch_target),
      .alu_out_ex_mem_o(alu_out_ex_mem), .rs2_ex_mem_o(rs2_ex_mem),
      .pc_plus_4_ex_mem_o(pc_plus_4_ex_mem), .rd_ex_mem_o(rd_ex_mem),
      .wb_sel_ex_mem_o(wb_sel_ex_mem), .reg_wb_en_ex_mem_o(reg_wb_en_ex_mem),
      .is_load_instr_ex_mem_o(is_load_instr_ex_mem),
      .is_store_instr_ex_mem_o(is_store_instr_ex_mem)
   );

   memory_stage u_mem (
      .clk_i(clk_i), .rst_i(rst_i), .freeze_i(freeze),
      .alu_out_i(alu_out_ex_mem), .rs2_i(rs2_ex_mem), .pc_plus_4_i(pc_plus_4_ex_mem),
      .rd_i(rd_ex_mem), .wb_sel_i(wb_sel_ex_mem), .reg_wb_en_i(reg_wb_en_ex_mem),
      .is_load_instr_i(is_load_instr_ex_mem), .is_store_instr_i(is_store_instr_ex_mem),
      .data_cache_data_i(data_cache_data_i), .data_cache_address_o(data_cache_address_o),
      .data_cache_write_en_o(data_cache_write_en_o), .data_cache_data_o(data_cache_data_o),
      .data_cache_enabled_o(data_cache_enabled_o), .load_val_o(load_val_mem_wb),
      .alu_out_o(alu_out_mem_wb), .pc_plus_4_o(pc_plus_4_mem_wb), .rd_label_o(rd_mem_wb),
      .wb_sel_o(wb_sel_mem_wb), .reg_wb_en_o(reg_wb_en_mem_wb)
   );

endmodule

/* testbench/core_tb.sv */
`timescale 1ns/1ns
`include "core_settings.svh"

module core_tb;
   localparam int STORE_TIMEOUT = 300; // cycles allowed between two stores
   localparam int QUIET_CYCLES = 60;
   localparam logic [6:0] f7_base = 7'h00;
   localparam logic [6:0] f7_sub = 7'h20;
   localparam logic [2:0] f3_word = 3'b010; // lw and sw

   logic clk, rst, instr_ready, data_ready;
   logic [31:2] instr_addr, data_addr;
   logic [`XLEN-1:0] instr_data, data_rdata, wdata;
   logic [3:0] write_en;
   logic data_en;
   logic [31:0] lfsr;

   logic [31:0] rom [64];
   logic [31:0] ram [256];
   logic [31:0] prog [$];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];

   core dut0 (
      .clk_i(clk), .rst_i(rst),
      .instr_cache_blocking_n_i(instr_ready), .data_cache_blocking_n_i(data_ready),
      .instr_cache_data_i(instr_data), .data_cache_data_i(data_rdata),
      .instr_cache_address_o(instr_addr), .data_cache_address_o(data_addr),
      .data_cache_write_en_o(write_en), .data_cache_data_o(wdata),
      .data_cache_enabled_o(data_en)
   );

   // RV32I encoders
   function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, isa_pkg::op};
   endfunction

   function automatic logic [31:0] enc_i(isa_pkg::opcode_e opc, logic [11:0] imm,
                                         logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, f3_word, imm[4:0], isa_pkg::store};
   endfunction

   function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isa_pkg::branch};
   endfunction

   function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd);
      return {imm, rd, isa_pkg::lui};
   endfunction

   function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::jal};
   endfunction

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function void add_instr(logic [31:0] word);
      prog.push_back(word);
   endfunction

   function void expect_store(logic [31:0] addr, logic [31:0] data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endfunction

   function automatic logic store_now();
      return data_en && data_ready && (write_en != 4'h0);
   endfunction

   task automatic build_program();
      logic [31:0] x1v, x2v, x3v, link;
      x1v = 32'h12345678;
      x2v = 32'hfffffffb;
      x3v = 32'd7;
      add_instr(enc_u(20'h12345, 5'd1));
      add_instr(enc_i(isa_pkg::op_imm, 12'h678, 5'd1, isa_pkg::f3_add_sub, 5'd1)); // dependent
      add_instr(enc_i(isa_pkg::op_imm, 12'hffb, 5'd0, isa_pkg::f3_add_sub, 5'd2)); // -5
      add_instr(enc_i(isa_pkg::op_imm, 12'h007, 5'd0, isa_pkg::f3_add_sub, 5'd3));
      add_instr(enc_r(f7_base, 5'd3, 5'd1, isa_pkg::f3_add_sub, 5'd4));
      add_instr(enc_s(12'h100, 5'd4, 5'd0));
      expect_store(32'h100, x1v + x3v);
      add_instr(enc_r(f7_sub, 5'd2, 5'd3, isa_pkg::f3_add_sub, 5'd4));
      add_instr(enc_s(12'h104, 5'd4, 5'd0));
      expect_store(32'h104, x3v - x2v);
      add_instr(enc_r(f7_base, 5'd2, 5'd1, isa_pkg::f3_and, 5'd4));
      add_instr(enc_s(12'h108, 5'd4, 5'd0));
      expect_store(32'h108, x1v & x2v);
      add_instr(enc_r(f7_base, 5'd2, 5'd1, isa_pkg::f3_or, 5'd4));
      add_instr(enc_s(12'h10c, 5'd4, 5'd0));
      expect_store(32'h10c, x1v | x2v);
      add_instr(enc_r(f7_base, 5'd3, 5'd1, isa_pkg::f3_xor, 5'd4));
      add_instr(enc_s(12'h110, 5'd4, 5'd0));
      expect_store(32'h110, x1v ^ x3v);
      add_instr(enc_r(f7_base, 5'd3, 5'd2, isa_pkg::f3_slt, 5'd4));
      add_instr(enc_s(12'h114, 5'd4, 5'd0));
      expect_store(32'h114, ($signed(x2v) < $signed(x3v)) ? 32'd1 : 32'd0);
      add_instr(enc_r(f7_base, 5'd3, 5'd1, isa_pkg::f3_sll, 5'd4));
      add_instr(enc_s(12'h118, 5'd4, 5'd0));
      expect_store(32'h118, x1v << x3v[4:0]);
      add_instr(enc_r(f7_base, 5'd3, 5'd2, isa_pkg::f3_srl, 5'd4));
      add_instr(enc_s(12'h11c, 5'd4, 5'd0));
      expect_store(32'h11c, x2v >> x3v[4:0]); // logical shift fills with zeros
      add_instr(enc_i(isa_pkg::op_imm, 12'h0f0, 5'd1, isa_pkg::f3_and, 5'd4));
      add_instr(enc_s(12'h120, 5'd4, 5'd0));
      expect_store(32'h120, x1v & 32'h0f0);
      add_instr(enc_i(isa_pkg::op_imm, 12'h700, 5'd3, isa_pkg::f3_or, 5'd4));
      add_instr(enc_s(12'h124, 5'd4, 5'd0));
      expect_store(32'h124, x3v | 32'h700);
      add_instr(enc_i(isa_pkg::op_imm, 12'hfff, 5'd1, isa_pkg::f3_xor, 5'd4));
      add_instr(enc_s(12'h128, 5'd4, 5'd0));
      expect_store(32'h128, x1v ^ 32'hffffffff); // immediate sign extended
      // load followed by use and store back
      add_instr(enc_i(isa_pkg::load, 12'h100, 5'd0, f3_word, 5'd5));
      add_instr(enc_i(isa_pkg::op_imm, 12'h001, 5'd5, isa_pkg::f3_add_sub, 5'd5));
      add_instr(enc_s(12'h12c, 5'd5, 5'd0));
      expect_store(32'h12c, x1v + x3v + 32'd1);
      add_instr(enc_b(13'd12, 5'd3, 5'd3, isa_pkg::f3_beq)); // taken and skips two stores
      add_instr(enc_s(12'h1f0, 5'd1, 5'd0));
      add_instr(enc_s(12'h1f4, 5'd1, 5'd0));
      add_instr(enc_b(13'd8, 5'd3, 5'd3, isa_pkg::f3_bne)); // not taken
      add_instr(enc_s(12'h130, 5'd3, 5'd0));
      expect_store(32'h130, x3v);
      link = {`RESET_PC + 30'(prog.size()), 2'b00} + 32'd4;
      add_instr(enc_j(21'd12, 5'd6));
      add_instr(enc_s(12'h1f8, 5'd1, 5'd0));
      add_instr(enc_s(12'h1fc, 5'd1, 5'd0));
      add_instr(enc_s(12'h134, 5'd6, 5'd0));
      expect_store(32'h134, link);
      add_instr(enc_j(21'd0, 5'd0)); // spin here
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("error %s: expected %h, actual %h", name, expected, actual);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic wait_for_store(input int n, output logic [31:0] addr,
                                 output logic [31:0] data, output logic [3:0] strobe);
      int cycles;
      cycles = 0;
      @(posedge clk);
      while (!store_now()) begin
         cycles++;
         if (cycles > STORE_TIMEOUT) begin
            $display("no store arrived within %0d cycles, waiting for store %0d",
                     STORE_TIMEOUT, n);
            $display("Test failed");
            $fatal(1);
         end
         @(posedge clk);
      end
      addr = {data_addr, 2'b00};
      data = wdata;
      strobe = write_en;
   endtask

   assign instr_data = rom[instr_addr[7:2]];
   assign data_rdata = ram[data_addr[9:2]];

   always @(posedge clk) begin
      if (data_en && data_ready && write_en == 4'hf)
         ram[data_addr[9:2]] <= wdata;
   end

   // one lfsr step for each ready bit
   always @(posedge clk) begin
      logic i_rdy, d_bit;
      lfsr = lfsr_step(lfsr);
      i_rdy = lfsr[0];
      lfsr = lfsr_step(lfsr);
      i_rdy = i_rdy | lfsr[0]; // ready three cycles in four
      lfsr = lfsr_step(lfsr);
      d_bit = lfsr[0];
      instr_ready <= i_rdy;
      data_ready <= i_rdy & d_bit; // an instruction miss freezes MEM and would repeat the access
   end

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      logic [31:0] addr, data;
      logic [3:0] strobe;
      rst = 1'b1;
      instr_ready = 1'b0;
      data_ready = 1'b0;
      lfsr = 32'h317a07bf;
      for (int i = 0; i < 64; i++)
         rom[i] = 32'(i) << 7; // opcode 0 decodes to a bubble
      for (int i = 0; i < 256; i++)
         ram[i] = 32'hda7a0000 + 32'(i);
      build_program();
      for (int i = 0; i < prog.size(); i++)
         rom[`RESET_PC + i] = prog[i];
      repeat (10) @(posedge clk);
      // state held by reset
      check_value("reset pc", {`RESET_PC, 2'b00}, {instr_addr, 2'b00});
      check_value("reset data enable", 32'd0, {31'b0, data_en});
      check_value("reset write enable", 32'd0, {28'b0, write_en});
      rst <= 1'b0;
      for (int n = 0; n < exp_addr.size(); n++) begin
         wait_for_store(n, addr, data, strobe);
         check_value($sformatf("store %0d address", n), exp_addr[n], addr);
         check_value($sformatf("store %0d data", n), exp_data[n], data);
         check_value($sformatf("store %0d strobe", n), 32'hf, {28'b0, strobe});
      end
      // the spin loop must not store again
      for (int c = 0; c < QUIET_CYCLES; c++) begin
         @(posedge clk);
         if (store_now()) begin
            $display("unexpected store to %h after the last expected store",
                     {data_addr, 2'b00});
            $display("Test failed");
            $fatal(1);
         end
      end
      $display("Test passed");
      $finish;
   end

endmodule

/* src.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instruction_fetch_stage.sv
hdl/instruction_decode_stage.sv
hdl/instruction_execution_stage.sv
hdl/memory_stage.sv
hdl/core.sv
testbench/core_tb.sv
